// File: hw/insn_decode.sv
// instruction decoder for the fetch stage
// register indices, immediate and control flags from one word
`default_nettype none

module insn_decode (
    input  rv32_pipe_pkg::word_t    insn,
    output rv32_pipe_pkg::reg_idx_t rs1,
    output rv32_pipe_pkg::reg_idx_t rs2,
    output rv32_pipe_pkg::reg_idx_t rd,
    output rv32_pipe_pkg::word_t    imm,
    output logic                    reg_write,
    output logic                    dren,
    output logic                    dwen,
    output logic                    jump,
    output logic                    illegal,
    output logic                    ecall,
    output logic                    mret
);
    import rv32_pipe_pkg::*;

    rv32_insn_t u;          // same word, two views
    logic       sys_base;   // funct3 zero, no registers named

    assign u = insn;
    assign sys_base = (u.itype.funct3 == 3'b000) && (u.itype.rs1 == '0) && (u.itype.rd == '0);

    always_comb begin
        // defaults describe a bubble
        rs1       = '0;
        rs2       = '0;
        rd        = '0;
        imm       = {{20{u.itype.imm12[11]}}, u.itype.imm12};   // i-type sign extend
        reg_write = 1'b0;
        dren      = 1'b0;
        dwen      = 1'b0;
        jump      = 1'b0;
        illegal   = 1'b0;
        ecall     = 1'b0;
        mret      = 1'b0;
        case (u.rtype.opcode)
            OP_REG: begin
                rs1       = u.rtype.rs1;
                rs2       = u.rtype.rs2;    // only r-type and store read rs2
                rd        = u.rtype.rd;
                reg_write = 1'b1;
            end
            OP_IMM, OP_LOAD: begin
                rs1       = u.itype.rs1;
                rd        = u.itype.rd;
                reg_write = 1'b1;
                dren      = (u.itype.opcode == OP_LOAD);
            end
            OP_STORE: begin
                rs1  = u.rtype.rs1;
                rs2  = u.rtype.rs2;
                dwen = 1'b1;                // rd stays 0, no write
            end
            OP_JAL: begin
                rd        = u.itype.rd;     // link register
                reg_write = 1'b1;
                jump      = 1'b1;
                // j-type immediate rebuilt from the i-type fields
                imm = {{11{u.itype.imm12[11]}}, u.itype.imm12[11], u.itype.rs1,
                       u.itype.funct3, u.itype.imm12[0], u.itype.imm12[10:1], 1'b0};
            end
            OP_SYSTEM: begin
                ecall   = sys_base && (u.itype.imm12 == F12_ECALL);
                mret    = sys_base && (u.itype.imm12 == F12_MRET);
                illegal = !ecall && !mret;  // no csr ops, ebreak etc
            end
            default: illegal = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/pc_sequencer.sv
// program counter register
// next pc select: privilege redirect, jump target, pc + 4
`default_nettype none

module pc_sequencer #(
    parameter rv32_pipe_pkg::word_t RESET_PC = 32'h0000_0100
) (
    input  logic                 CLK,
    input  logic                 arst_n,
    input  logic                 pc_en,
    input  logic                 npc_sel,         // jal resolved in execute
    input  rv32_pipe_pkg::word_t jump_target,
    input  logic                 insert_priv_pc,  // trap or mret
    input  rv32_pipe_pkg::word_t priv_pc,
    output rv32_pipe_pkg::word_t pc
);
    import rv32_pipe_pkg::*;

    word_t next_pc;

    always_comb begin
        if (insert_priv_pc)
            next_pc = priv_pc;          // privilege redirect wins
        else if (npc_sel)
            next_pc = jump_target;
        else
            next_pc = pc + 32'd4;
    end

    always_ff @(posedge CLK, negedge arst_n) begin
        if (!arst_n)
            pc <= RESET_PC;
        else if (pc_en)
            pc <= next_pc;              // hold while fetch is stalled
    end

endmodule

`default_nettype wire

// File: hw/pipe_ctrl_top.sv
// top of the pipeline control subsystem
// decoder, pc, latches, hazard unit and trap block, gated data strobes
`default_nettype none

module pipe_ctrl_top #(
    parameter rv32_pipe_pkg::word_t RESET_PC    = 32'h0000_0100,
    parameter rv32_pipe_pkg::word_t TRAP_VECTOR = 32'h0000_0040
) (
    input  logic                    CLK,
    input  logic                    arst_n,
    input  rv32_pipe_pkg::word_t    insn,
    input  logic                    i_mem_busy,
    input  logic                    d_mem_busy,
    input  logic                    ex_busy,
    input  logic                    halt,
    input  logic                    intr,
    output rv32_pipe_pkg::word_t    imem_addr,
    output logic                    dmem_ren,
    output logic                    dmem_wen,
    output logic                    retire_valid,
    output rv32_pipe_pkg::word_t    retire_pc,
    output rv32_pipe_pkg::reg_idx_t retire_rd,
    output logic                    trap_taken,
    output rv32_pipe_pkg::word_t    epc,
    output logic [3:0]              cause
);
    import rv32_pipe_pkg::*;

    word_t    pc, imm_d, imm_e, pc_e, pc_m, priv_pc;
    reg_idx_t rs1_d, rs2_d, rd_d, rs1_e, rs2_e, rd_m;
    logic     reg_write_d, dren_d, dwen_d, jump_d, illegal_d, ecall_d, mret_d;
    logic     valid_e, jump_e, valid_m, reg_write_m, dren_m, dwen_m;
    logic     illegal_m, ecall_m, mret_m;
    logic     pc_en, npc_sel, if_ex_stall, if_ex_flush, ex_mem_stall, ex_mem_flush;
    logic     suppress_data, retire, exception, intr_take, insert_pc, ret_pulse;

    assign imem_addr    = pc;
    assign dmem_ren     = valid_m && dren_m && !suppress_data;
    assign dmem_wen     = valid_m && dwen_m && !suppress_data;
    assign retire_valid = retire;
    assign retire_pc    = pc_m;
    assign retire_rd    = rd_m;

    insn_decode u_dec (
        .insn, .rs1(rs1_d), .rs2(rs2_d), .rd(rd_d), .imm(imm_d),
        .reg_write(reg_write_d), .dren(dren_d), .dwen(dwen_d), .jump(jump_d),
        .illegal(illegal_d), .ecall(ecall_d), .mret(mret_d)
    );

    pc_sequencer #(.RESET_PC(RESET_PC)) u_pc (
        .CLK, .arst_n, .pc_en, .npc_sel,
        .jump_target(pc_e + imm_e),     // jal target from execute
        .insert_priv_pc(insert_pc), .priv_pc, .pc
    );

    pipe_latches u_latch (
        .CLK, .arst_n, .rs1_d, .rs2_d, .rd_d, .imm_d, .reg_write_d, .dren_d,
        .dwen_d, .jump_d, .illegal_d, .ecall_d, .mret_d, .fetch_pc(pc),
        .if_ex_stall, .if_ex_flush, .ex_mem_stall, .ex_mem_flush,
        .valid_e, .pc_e, .rs1_e, .rs2_e, .imm_e, .jump_e,
        .valid_m, .pc_m, .rd_m, .reg_write_m, .dren_m, .dwen_m,
        .illegal_m, .ecall_m, .mret_m
    );

    stage3_hazard_unit u_hazard (
        .rs1_e, .rs2_e, .rd_m, .reg_write_m, .dren_m, .dwen_m, .jump_e,
        .valid_m, .valid_e, .exception, .intr_take, .ret_pulse, .insert_pc,
        .i_mem_busy, .d_mem_busy, .ex_busy, .halt,
        .pc_en, .npc_sel, .if_ex_stall, .if_ex_flush, .ex_mem_stall,
        .ex_mem_flush, .suppress_data, .retire
    );

    trap_ctrl #(.TRAP_VECTOR(TRAP_VECTOR)) u_trap (
        .CLK, .arst_n, .valid_m, .illegal_m, .ecall_m, .mret_m, .intr,
        .pc_m, .pc_e, .pc_f(pc), .valid_e,
        .stall_m(ex_mem_stall),         // no trap while memory holds
        .exception, .intr_take, .insert_pc, .ret_pulse, .priv_pc,
        .epc, .cause, .trap_taken
    );

endmodule

`default_nettype wire

// File: hw/pipe_latches.sv
// if_ex and ex_mem pipeline registers
// control bits reset and flush to a bubble, payload only loads
`default_nettype none

module pipe_latches (
    input  logic                    CLK,
    input  logic                    arst_n,
    // decode fields of the fetched word
    input  rv32_pipe_pkg::reg_idx_t rs1_d,
    input  rv32_pipe_pkg::reg_idx_t rs2_d,
    input  rv32_pipe_pkg::reg_idx_t rd_d,
    input  rv32_pipe_pkg::word_t    imm_d,
    input  logic                    reg_write_d,
    input  logic                    dren_d,
    input  logic                    dwen_d,
    input  logic                    jump_d,
    input  logic                    illegal_d,
    input  logic                    ecall_d,
    input  logic                    mret_d,
    input  rv32_pipe_pkg::word_t    fetch_pc,
    input  logic                    if_ex_stall,
    input  logic                    if_ex_flush,
    input  logic                    ex_mem_stall,
    input  logic                    ex_mem_flush,
    // execute stage
    output logic                    valid_e,
    output rv32_pipe_pkg::word_t    pc_e,
    output rv32_pipe_pkg::reg_idx_t rs1_e,
    output rv32_pipe_pkg::reg_idx_t rs2_e,
    output rv32_pipe_pkg::word_t    imm_e,
    output logic                    jump_e,
    // memory stage
    output logic                    valid_m,
    output rv32_pipe_pkg::word_t    pc_m,
    output rv32_pipe_pkg::reg_idx_t rd_m,
    output logic                    reg_write_m,
    output logic                    dren_m,
    output logic                    dwen_m,
    output logic                    illegal_m,
    output logic                    ecall_m,
    output logic                    mret_m
);
    import rv32_pipe_pkg::*;

    // {valid, jump, reg_write, dren, dwen, illegal, ecall, mret}
    logic [7:0] ctrl_e;
    logic [6:0] ctrl_m;     // same minus jump
    reg_idx_t   rd_e;

    assign valid_e = ctrl_e[7];
    assign jump_e  = ctrl_e[6];
    assign {valid_m, reg_write_m, dren_m, dwen_m, illegal_m, ecall_m, mret_m} = ctrl_m;

    // control, flush beats stall
    always_ff @(posedge CLK, negedge arst_n) begin
        if (!arst_n) begin
            ctrl_e <= '0;
            ctrl_m <= '0;
        end else begin
            if (if_ex_flush)
                ctrl_e <= '0;
            else if (!if_ex_stall)  // fetch always valid, pending fetch is flushed
                ctrl_e <= {1'b1, jump_d, reg_write_d, dren_d, dwen_d, illegal_d, ecall_d, mret_d};
            if (ex_mem_flush)
                ctrl_m <= '0;
            else if (!ex_mem_stall)
                ctrl_m <= {ctrl_e[7], ctrl_e[5:0]};
        end
    end

    // payload, meaningless under a cleared valid
    always_ff @(posedge CLK) begin
        if (!if_ex_stall) begin
            pc_e  <= fetch_pc;
            rs1_e <= rs1_d;
            rs2_e <= rs2_d;
            rd_e  <= rd_d;
            imm_e <= imm_d;
        end
        if (!ex_mem_stall) begin
            pc_m <= pc_e;
            rd_m <= rd_e;
        end
    end

endmodule

`default_nettype wire

// File: hw/rv32_pipe_pkg.sv
// shared definitions for the rv32i pipeline control subsystem
// word and register index types, instruction union with two views
// opcodes, system funct12 values and trap cause codes
`default_nettype none

package rv32_pipe_pkg;

    typedef logic [31:0] word_t;    // pc, epc, instruction word
    typedef logic [4:0]  reg_idx_t;

    // one instruction word, read as r-type or i-type
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            reg_idx_t   rs2;
            reg_idx_t   rs1;
            logic [2:0] funct3;
            reg_idx_t   rd;
            logic [6:0] opcode;
        } rtype;
        struct packed {
            logic [11:0] imm12;     // also funct12 for system insns
            reg_idx_t    rs1;
            logic [2:0]  funct3;
            reg_idx_t    rd;
            logic [6:0]  opcode;
        } itype;
    } rv32_insn_t;

    // major opcodes
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_SYSTEM = 7'b1110011;

    // funct12 field of system insns
    localparam logic [11:0] F12_ECALL = 12'h000;
    localparam logic [11:0] F12_MRET  = 12'h302;

    // trap causes, interrupt additionally flagged by bit 3
    localparam logic [3:0] CAUSE_ILLEGAL = 4'd2;
    localparam logic [3:0] CAUSE_ECALL   = 4'd11;
    localparam logic [3:0] CAUSE_INTR    = 4'hB;

endpackage

`default_nettype wire

// File: hw/stage3_hazard_unit.sv
// hazard unit of the three stage pipeline
// stall chain, flushes, pc enable, data suppression and retire
`default_nettype none

module stage3_hazard_unit (
    input  rv32_pipe_pkg::reg_idx_t rs1_e,
    input  rv32_pipe_pkg::reg_idx_t rs2_e,
    input  rv32_pipe_pkg::reg_idx_t rd_m,
    input  logic                    reg_write_m,
    input  logic                    dren_m,
    input  logic                    dwen_m,
    input  logic                    jump_e,
    input  logic                    valid_m,
    input  logic                    valid_e,
    input  logic                    exception,   // illegal or ecall in memory
    input  logic                    intr_take,
    input  logic                    ret_pulse,
    input  logic                    insert_pc,
    input  logic                    i_mem_busy,
    input  logic                    d_mem_busy,
    input  logic                    ex_busy,
    input  logic                    halt,
    output logic                    pc_en,
    output logic                    npc_sel,
    output logic                    if_ex_stall,
    output logic                    if_ex_flush,
    output logic                    ex_mem_stall,
    output logic                    ex_mem_flush,
    output logic                    suppress_data,
    output logic                    retire
);
    logic rs1_match;
    logic rs2_match;
    logic dmem_access;
    logic wait_for_imem;
    logic wait_for_dmem;
    logic mem_use_stall;
    logic branch_jump;
    logic ex_flush_hazard;

    // load in memory feeding the insn in execute, x0 never hazards
    assign rs1_match = (rs1_e == rd_m) && (rd_m != '0);
    assign rs2_match = (rs2_e == rd_m) && (rd_m != '0);
    assign mem_use_stall = valid_e && valid_m && reg_write_m && dren_m
                         && (rs1_match || rs2_match);   // no forward from mem

    assign dmem_access   = dren_m || dwen_m;
    assign suppress_data = exception;       // faulting insn touches no memory
    assign wait_for_imem = i_mem_busy;      // fetch requested every cycle
    assign wait_for_dmem = dmem_access && d_mem_busy && !suppress_data;

    // jal resolved in execute, only once memory can take it
    assign branch_jump = valid_e && jump_e && !ex_mem_stall;
    assign npc_sel     = branch_jump;

    // trap or mret in memory, never while memory holds
    assign ex_flush_hazard = ((exception || intr_take) && !ex_mem_stall) || ret_pulse;

    // memory slow or halted, everything holds
    assign ex_mem_stall = wait_for_dmem || halt;

    // stall of memory stalls execute too
    assign if_ex_stall = ex_mem_stall
                       || (ex_busy && !ex_flush_hazard && !branch_jump)
                       || mem_use_stall;                // one cycle, rd_m then clears

    assign if_ex_flush = ex_flush_hazard
                       || branch_jump                   // kill wrong-path fetch
                       || (wait_for_imem && !if_ex_stall);  // bubble for slow fetch

    // bubble into memory when execute holds but memory moves on
    assign ex_mem_flush = ex_flush_hazard
                        || (if_ex_stall && !ex_mem_stall);

    // pc moves when fetch hands off, or on any redirect
    assign pc_en = (!if_ex_stall && !wait_for_imem)
                 || branch_jump
                 || ex_flush_hazard
                 || insert_pc;

    assign retire = valid_m && !ex_mem_stall && !exception;

endmodule

`default_nettype wire

// File: hw/trap_ctrl.sv
// reduced privilege block
// trap detect, epc and cause registers, trap and mret redirect
`default_nettype none

module trap_ctrl #(
    parameter rv32_pipe_pkg::word_t TRAP_VECTOR = 32'h0000_0040
) (
    input  logic                 CLK,
    input  logic                 arst_n,
    input  logic                 valid_m,
    input  logic                 illegal_m,
    input  logic                 ecall_m,
    input  logic                 mret_m,
    input  logic                 intr,
    input  rv32_pipe_pkg::word_t pc_m,
    input  rv32_pipe_pkg::word_t pc_e,
    input  rv32_pipe_pkg::word_t pc_f,
    input  logic                 valid_e,
    input  logic                 stall_m,
    output logic                 exception,
    output logic                 intr_take,
    output logic                 insert_pc,
    output logic                 ret_pulse,
    output rv32_pipe_pkg::word_t priv_pc,
    output rv32_pipe_pkg::word_t epc,
    output logic [3:0]           cause,
    output logic                 trap_taken
);
    import rv32_pipe_pkg::*;

    logic  intr_en;     // off from trap entry until mret
    logic  trap;
    word_t epc_next;

    assign exception = valid_m && (illegal_m || ecall_m);
    // exceptions and a retiring mret mask the interrupt
    assign intr_take = intr && intr_en && !exception && !(valid_m && mret_m) && !stall_m;
    assign ret_pulse = valid_m && mret_m && !stall_m;
    assign trap      = (exception && !stall_m) || intr_take;
    assign insert_pc = trap || ret_pulse;
    assign priv_pc   = trap ? TRAP_VECTOR : epc;

    // interrupt lets the memory insn finish, restart at the oldest one left
    assign epc_next = (valid_m && !intr_take) ? pc_m :
                      (valid_e ? pc_e : pc_f);

    always_ff @(posedge CLK, negedge arst_n) begin
        if (!arst_n) begin
            epc        <= '0;
            cause      <= '0;
            trap_taken <= 1'b0;
            intr_en    <= 1'b1;
        end else begin
            trap_taken <= trap;         // one cycle per trap
            if (trap) begin
                epc     <= epc_next;
                intr_en <= 1'b0;
                if (intr_take)
                    cause <= CAUSE_INTR | 4'b1000;
                else if (ecall_m)
                    cause <= CAUSE_ECALL;
                else
                    cause <= CAUSE_ILLEGAL;
            end else if (ret_pulse) begin
                intr_en <= 1'b1;        // back to the interrupted code
            end
        end
    end

endmodule

`default_nettype wire

// File: pipe_ctrl.f
hw/rv32_pipe_pkg.sv
hw/insn_decode.sv
hw/pc_sequencer.sv
hw/pipe_latches.sv
hw/stage3_hazard_unit.sv
hw/trap_ctrl.sv
hw/pipe_ctrl_top.sv
verification/pipe_ctrl_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the pipeline control testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f pipe_ctrl.f --top-module pipe_ctrl_tb -o pipe_ctrl_sim
./obj_dir/pipe_ctrl_sim > sim.log
cat sim.log

if grep -q "\*\*\* TEST FAILED \*\*\*" sim.log; then
    exit 1
fi
exit 0

// File: verification/pipe_ctrl_tb.sv
// testbench for pipe_ctrl_top
// instruction memory model, directed and random programs
// retire, trap and strobe checks by immediate assertions at negedge
`default_nettype none

module pipe_ctrl_tb;
    localparam logic [31:0] RESET_PC = 32'h0000_0100;
    localparam logic [31:0] TRAP_VEC = 32'h0000_0040;
    localparam int TOTAL_CYCLES = 30 + 30 + 30 + 30 + 30 + 40 + 300;  // per test budgets

    logic        CLK = 1'b0;
    logic        arst_n = 1'b0;
    logic        i_mem_busy = 1'b0;
    logic        d_mem_busy = 1'b0;
    logic        ex_busy = 1'b0;
    logic        halt = 1'b0;
    logic        intr = 1'b0;
    logic [31:0] insn, imem_addr, retire_pc, epc;
    logic [4:0]  retire_rd;
    logic [3:0]  cause;
    logic        dmem_ren, dmem_wen, retire_valid, trap_taken;

    logic [31:0] imem [0:255];
    logic [31:0] exp_pc [0:127];        // expected retirements in program order
    logic [4:0]  exp_rd [0:127];
    int          exp_dt [0:127];        // cycles since previous retire, 0 = any
    int          exp_kind [0:127];      // 0 alu, 1 load, 2 store, 3 mret
    int          wr_idx = 0;
    int          rd_idx = 0;
    logic [31:0] exp_epc = '0;
    logic [3:0]  exp_cause = '0;
    int          seed = 74848;
    logic        bp_on = 1'b0;
    int          errors = 0;            // monitor checks
    int          task_errs = 0;         // checks in the main sequence
    int          tests_bad = 0;
    int          cyc = 0;
    int          last_ret = 0;
    int          trap_cnt = 0;
    int          busy_len = 0;
    logic        mret_chk = 1'b0;
    logic        prev_hold = 1'b0;
    logic [31:0] prev_addr = '0;

    pipe_ctrl_top #(.RESET_PC(RESET_PC), .TRAP_VECTOR(TRAP_VEC)) dut (
        .CLK, .arst_n, .insn, .i_mem_busy, .d_mem_busy, .ex_busy, .halt, .intr,
        .imem_addr, .dmem_ren, .dmem_wen, .retire_valid, .retire_pc, .retire_rd,
        .trap_taken, .epc, .cause
    );

    assign insn = imem[imem_addr[9:2]];    // combinational fetch

    always #20 CLK = ~CLK;

    always @(posedge CLK) cyc <= cyc + 1;

    // instruction encoders
    function automatic logic [31:0] addi_word(logic [4:0] rd, logic [4:0] rs1, logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction
    function automatic logic [31:0] add_word(logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
        return {7'd0, rs2, rs1, 3'b000, rd, 7'b0110011};
    endfunction
    function automatic logic [31:0] lw_word(logic [4:0] rd, logic [4:0] rs1);
        return {12'd0, rs1, 3'b010, rd, 7'b0000011};
    endfunction
    function automatic logic [31:0] sw_word(logic [4:0] rs1, logic [4:0] rs2);
        return {7'd0, rs2, rs1, 3'b010, 5'd0, 7'b0100011};
    endfunction
    function automatic logic [31:0] jal_word(logic [4:0] rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic logic [4:0] rand_reg();
        int r;
        r = $random(seed);
        return {r[4:1], 1'b1};          // never x0
    endfunction

    // back-pressure source, random busy bursts
    always @(posedge CLK) begin
        int r;
        #1;
        if (bp_on) begin
            r = $random(seed);
            if (busy_len == 0) begin
                busy_len = (r & 3) + 1;
                d_mem_busy = r[4];
            end
            busy_len = busy_len - 1;
            i_mem_busy = r[8] & r[9];
            ex_busy = r[12] & r[13];
            halt = (r[18:16] == 3'd0);  // rare
        end else begin
            d_mem_busy = 1'b0;
            i_mem_busy = 1'b0;
            ex_busy = 1'b0;
            halt = 1'b0;
        end
    end

    always @(negedge CLK) begin
        if (!arst_n) begin
            last_ret = cyc + 1;         // count of the release edge
            prev_hold = 1'b0;
            mret_chk = 1'b0;
            assert (imem_addr == RESET_PC && !retire_valid && !trap_taken && !dmem_ren
                    && !dmem_wen && epc == '0 && cause == '0) else begin
                errors++;
                $display("FAILED reset state: imem_addr %h retire_valid %h trap_taken %h",
                         imem_addr, retire_valid, trap_taken);
                $display("FAILED reset state: dmem_ren %h dmem_wen %h epc %h cause %h",
                         dmem_ren, dmem_wen, epc, cause);
            end
        end else begin
            if (mret_chk)
                assert (imem_addr == exp_epc) else begin
                    errors++;
                    $display("FAILED imem_addr after mret: got %h expected %h",
                             imem_addr, exp_epc);
                end
            mret_chk = 1'b0;
            if (prev_hold)
                assert (imem_addr == prev_addr) else begin
                    errors++;
                    $display("FAILED imem_addr under hold: got %h expected %h",
                             imem_addr, prev_addr);
                end
            if (retire_valid && rd_idx != wr_idx) begin
                assert (retire_pc == exp_pc[rd_idx] && retire_rd == exp_rd[rd_idx]) else begin
                    errors++;
                    $display("FAILED retire_pc/retire_rd: got %h/%h expected %h/%h",
                             retire_pc, retire_rd, exp_pc[rd_idx], exp_rd[rd_idx]);
                end
                if (exp_dt[rd_idx] != 0)
                    assert (cyc - last_ret == exp_dt[rd_idx]) else begin
                        errors++;
                        $display("retire of pc %h came %0d cycles after the previous one, not %0d",
                                 retire_pc, cyc - last_ret, exp_dt[rd_idx]);
                    end
                assert (dmem_ren == (exp_kind[rd_idx] == 1) && dmem_wen == (exp_kind[rd_idx] == 2))
                else begin
                    errors++;
                    $display("FAILED dmem_ren/dmem_wen at retire: got %h/%h expected %h/%h",
                             dmem_ren, dmem_wen, exp_kind[rd_idx] == 1, exp_kind[rd_idx] == 2);
                end
                mret_chk = (exp_kind[rd_idx] == 3);
                last_ret = cyc;
                rd_idx++;
            end
            if (trap_taken) begin
                trap_cnt++;
                assert (epc == exp_epc && cause == exp_cause && imem_addr == TRAP_VEC) else begin
                    errors++;
                    $display("FAILED epc/cause/imem_addr at trap: got %h/%h/%h expected %h/%h/%h",
                             epc, cause, imem_addr, exp_epc, exp_cause, TRAP_VEC);
                end
            end
            // a strobe only stays up while held or on the retiring access
            assert (!(dmem_ren || dmem_wen) || retire_valid || d_mem_busy || halt) else begin
                errors++;
                $display("data strobe raised by an instruction that does not retire");
            end
            if ((d_mem_busy && (dmem_ren || dmem_wen)) || halt)
                assert (!retire_valid) else begin
                    errors++;
                    $display("FAILED retire_valid under hold: got %h expected 0", retire_valid);
                end
            prev_hold = (d_mem_busy && (dmem_ren || dmem_wen)) || halt;
            prev_addr = imem_addr;
        end
    end

    task automatic expect_retire(logic [31:0] pc, logic [4:0] rd, int dt, int kind);
        exp_pc[wr_idx] = pc;
        exp_rd[wr_idx] = rd;
        exp_dt[wr_idx] = dt;
        exp_kind[wr_idx] = kind;
        wr_idx++;
    endtask

    task automatic place(logic [31:0] addr, logic [31:0] word);
        imem[addr[9:2]] = word;
    endtask

    // fill with x0 nops carrying their own index, then hold reset 4 cycles
    task automatic start_test();
        for (int i = 0; i < 256; i++)
            imem[i] = addi_word(5'd0, 5'd0, 12'(i));
        @(posedge CLK);
        #1 arst_n = 1'b0;
        repeat (4) @(posedge CLK);
        #1 arst_n = 1'b1;
    endtask

    task automatic end_test(string name, int traps_before, int traps_exp);
        while (rd_idx != wr_idx)
            @(posedge CLK);
        repeat (2) @(posedge CLK);
        if (trap_cnt - traps_before != traps_exp) begin
            task_errs++;
            $display("test %s saw %0d traps instead of %0d", name, trap_cnt - traps_before, traps_exp);
        end
        $display("test %s done", name);
    endtask

    task automatic trap_test(string name, logic [31:0] bad, logic [3:0] c);
        int t0;
        int e0;
        e0 = errors + task_errs;
        t0 = trap_cnt;
        exp_epc = 32'h108;
        exp_cause = c;
        start_test();
        place(32'h100, addi_word(5'd1, 5'd0, 12'd1));
        place(32'h104, addi_word(5'd2, 5'd0, 12'd2));
        place(32'h108, bad);
        place(32'h10c, sw_word(5'd1, 5'd2));   // flushed, must not strobe
        place(TRAP_VEC, addi_word(5'd11, 5'd0, 12'd3));
        expect_retire(32'h100, 5'd1, 2, 0);
        expect_retire(32'h104, 5'd2, 1, 0);
        expect_retire(TRAP_VEC, 5'd11, 4, 0);
        end_test(name, t0, 1);
        if (errors + task_errs != e0)
            tests_bad++;
    endtask

    initial begin
        int e0;
        int t0;
        logic [4:0] r;
        logic [31:0] w;
        int sel;
        logic [3:0] ck;

        // reset values and straight-line ALU code
        e0 = errors + task_errs;
        t0 = trap_cnt;
        start_test();
        for (int i = 0; i < 6; i++) begin
            r = rand_reg();
            place(RESET_PC + 32'(4 * i), addi_word(r, 5'd0, 12'(i)));
            expect_retire(RESET_PC + 32'(4 * i), r, (i == 0) ? 2 : 1, 0);
        end
        end_test("straight_line", t0, 0);
        if (errors + task_errs != e0) tests_bad++;

        // dependent, independent and x0 followers of loads
        e0 = errors + task_errs;
        start_test();
        place(32'h100, lw_word(5'd5, 5'd1));
        place(32'h104, add_word(5'd6, 5'd5, 5'd2));
        place(32'h108, lw_word(5'd7, 5'd1));
        place(32'h10c, add_word(5'd8, 5'd3, 5'd4));
        place(32'h110, lw_word(5'd0, 5'd1));
        place(32'h114, add_word(5'd9, 5'd0, 5'd0));
        expect_retire(32'h100, 5'd5, 2, 1);
        expect_retire(32'h104, 5'd6, 2, 0);    // one bubble
        expect_retire(32'h108, 5'd7, 1, 1);
        expect_retire(32'h10c, 5'd8, 1, 0);
        expect_retire(32'h110, 5'd0, 1, 1);
        expect_retire(32'h114, 5'd9, 1, 0);
        end_test("load_use", trap_cnt, 0);
        if (errors + task_errs != e0) tests_bad++;

        // jal skips its fall-through slot
        e0 = errors + task_errs;
        start_test();
        place(32'h100, addi_word(5'd1, 5'd0, 12'd7));
        place(32'h104, jal_word(5'd1, 21'd16));
        place(32'h108, addi_word(5'd20, 5'd0, 12'd1));
        place(32'h114, addi_word(5'd9, 5'd0, 12'd2));
        expect_retire(32'h100, 5'd1, 2, 0);
        expect_retire(32'h104, 5'd1, 1, 0);
        expect_retire(32'h114, 5'd9, 2, 0);
        end_test("jal", trap_cnt, 0);
        if (errors + task_errs != e0) tests_bad++;

        trap_test("illegal", 32'hffff_ffff, 4'd2);
        trap_test("ecall", 32'h0000_0073, 4'd11);

        // interrupt while 0x104 is in memory, handler returns by mret
        e0 = errors + task_errs;
        t0 = trap_cnt;
        exp_epc = 32'h108;
        exp_cause = 4'hB;
        start_test();
        for (int i = 0; i < 5; i++)
            place(RESET_PC + 32'(4 * i), addi_word(5'(i + 1), 5'd0, 12'd1));
        place(TRAP_VEC, addi_word(5'd12, 5'd0, 12'd5));
        place(TRAP_VEC + 32'h4, 32'h3020_0073);
        expect_retire(32'h100, 5'd1, 2, 0);
        expect_retire(32'h104, 5'd2, 1, 0);
        expect_retire(TRAP_VEC, 5'd12, 3, 0);
        expect_retire(TRAP_VEC + 32'h4, 5'd0, 1, 3);
        expect_retire(32'h108, 5'd3, 3, 0);
        expect_retire(32'h10c, 5'd4, 1, 0);
        expect_retire(32'h110, 5'd5, 1, 0);
        repeat (3) @(posedge CLK);
        #1 intr = 1'b1;
        @(posedge CLK);
        #1 intr = 1'b0;
        end_test("interrupt", t0, 1);
        if (errors + task_errs != e0) tests_bad++;

        // random mix under random busy, ex_busy and halt
        e0 = errors + task_errs;
        start_test();
        for (int i = 0; i < 12; i++) begin
            r = rand_reg();
            sel = $random(seed) & 3;
            ck = 4'(sel == 1 ? 1 : (sel == 2 ? 2 : 0));
            case (sel)
                0: w = addi_word(r, rand_reg(), 12'(i));
                1: w = lw_word(r, rand_reg());
                2: w = sw_word(rand_reg(), rand_reg());
                default: w = add_word(r, rand_reg(), rand_reg());
            endcase
            place(RESET_PC + 32'(4 * i), w);
            expect_retire(RESET_PC + 32'(4 * i), (sel == 2) ? 5'd0 : r, 0, int'(ck));
        end
        @(negedge CLK);                 // busy source starts with the first fetch
        bp_on = 1'b1;
        end_test("back_pressure", trap_cnt, 0);
        bp_on = 1'b0;
        if (errors + task_errs != e0) tests_bad++;

        $display("tests run 7, tests with errors %0d, failed checks %0d",
                 tests_bad, errors + task_errs);
        if (errors + task_errs == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        #(TOTAL_CYCLES * 2 * 40);
        $display("watchdog expired, the run did not finish in time");
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire
